// ==== tb.f ====
hw/rv32i_pkg.sv
hw/imm_gen.sv
hw/rv32i_decoder.sv
hw/register_file.sv
hw/decode_stage.sv
hw/id_ex_reg.sv
hw/id_top.sv
test/tb_id_top.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the ID stage testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module tb_id_top -o Vtb_id_top
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/Vtb_id_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "ALL CHECKS PASSED" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0

// ==== test/tb_id_top.sv ====
`timescale 1ns/1ns

module tb_id_top
    import rv32i_pkg::*;
;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;
    localparam int N_RAND       = 16;
    // Cycles spent by each test after reset, in run order
    localparam int TEST_CYCLES  = 1 + 65 + 8 + 8 * N_RAND + 37 + N_RAND;
    localparam int WATCHDOG_NS  = 2 * (RESET_CYCLES + TEST_CYCLES) * CLK_PERIOD;

    // R-type table {funct7 bit 30, funct3, ALU op} from the RV32I spec
    localparam logic [7:0] R_TABLE [10] = '{
        {1'b0, 3'b000, ALU_ADD}, {1'b1, 3'b000, ALU_SUB}, {1'b0, 3'b001, ALU_SLL},
        {1'b0, 3'b010, ALU_SLT}, {1'b0, 3'b011, ALU_SLTU}, {1'b0, 3'b100, ALU_XOR},
        {1'b0, 3'b101, ALU_SRL}, {1'b1, 3'b101, ALU_SRA}, {1'b0, 3'b110, ALU_OR},
        {1'b0, 3'b111, ALU_AND}
    };
    // Branch kind by funct3
    // Codes 2 and 3 are not branches
    localparam logic [2:0] BR_OF_F3 [8] = '{
        BR_EQ, BR_NE, BR_NONE, BR_NONE, BR_LT, BR_GE, BR_LTU, BR_GEU
    };
    // System, fence, all zeros, all ones
    localparam logic [6:0] BAD_OPC [4] = '{7'b1110011, 7'b0001111, 7'b0000000, 7'b1111111};

    logic        clk;
    logic        rst;
    logic        bubble;
    logic [31:0] instr;
    logic [31:0] pc_plus;
    logic        pred;
    logic [5:0]  wb_ctrl;
    logic [31:0] wb_data;
    logic [31:0] ex_a;
    logic [31:0] ex_b;
    logic [31:0] ex_st;
    logic [31:0] ex_pc;
    logic [25:0] ex_ctrl;
    branch_sel_e ex_br;
    logic        ex_pred;

    // Register model and expected ID/EX contents
    logic [31:0] model [32];
    logic [31:0] pend_a;
    logic [31:0] pend_b;
    logic [31:0] pend_st;
    logic [31:0] pend_pc;
    logic [25:0] pend_ctrl;
    logic [2:0]  pend_br;
    logic        pend_pred;

    logic [31:0] seed = 32'h6e8d8f4a;
    int          checks = 0;
    int          errors = 0;
    int          test_start_err;

    id_top dut (
        .clk                    (clk),
        .rst_i                  (rst),
        .bubble_i               (bubble),
        .instr_i                (instr),
        .pc_plus_i              (pc_plus),
        .branch_prediction_i    (pred),
        .wb_ctrl_i              (wb_ctrl),
        .wb_data_i              (wb_data),
        .ex_data_a_o            (ex_a),
        .ex_data_b_o            (ex_b),
        .ex_store_data_o        (ex_st),
        .ex_pc_plus_o           (ex_pc),
        .ex_ctrl_o              (ex_ctrl),
        .ex_branch_sel_o        (ex_br),
        .ex_branch_prediction_o (ex_pred)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("CHECKS FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    // LCG step
    function logic [31:0] rand32();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [4:0] rand_reg();
        logic [31:0] t;
        t = rand32();
        return t[12:8];
    endfunction

    // Expected control word from flags {use_imm, mem_write, mem_read, reg_write}
    function automatic logic [25:0] cw(input logic [3:0] f, input logic [3:0] alu,
                                       input logic [2:0] f3, input logic [4:0] rs1,
                                       input logic [4:0] rs2, input logic [4:0] rd);
        logic [25:0] c;
        c                  = '0;
        c[CW_REG_WRITE]    = f[0];
        c[CW_MEM_READ]     = f[1];
        c[CW_MEM_WRITE]    = f[2];
        c[CW_USE_IMM]      = f[3];
        c[CW_ALU_OP +: 4]  = alu;
        c[CW_FUNCT3 +: 3]  = f3;
        c[CW_RS1 +: 5]     = rs1;
        c[CW_RS2 +: 5]     = rs2;
        c[CW_RD +: 5]      = rd;
        return c;
    endfunction

    // Instruction encoders
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    // Bit 0 of a branch or jump offset is not encoded
    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] x);
        return {{20{x[11]}}, x};
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("CHECK FAILED %s expected %h got %h", name, exp, act);
        end
    endtask

    task automatic check_outputs();
        check_val("ex_ctrl_o", 32'(pend_ctrl), 32'(ex_ctrl));
        check_val("ex_branch_sel_o", 32'(pend_br), 32'(ex_br));
        check_val("ex_data_a_o", pend_a, ex_a);
        check_val("ex_data_b_o", pend_b, ex_b);
        check_val("ex_store_data_o", pend_st, ex_st);
        check_val("ex_pc_plus_o", pend_pc, ex_pc);
        check_val("ex_branch_prediction_o", 32'(pend_pred), 32'(ex_pred));
    endtask

    // Writeback drive with the model updated at once
    task automatic set_wb(input logic [4:0] k, input logic [31:0] v);
        wb_ctrl = {k, 1'b1};
        wb_data = v;
        if (k != 5'd0) begin
            model[k] = v;
        end
    endtask

    task automatic clear_wb();
        wb_ctrl = '0;
        wb_data = '0;
    endtask

    // Drives one instruction at a falling edge and checks it one cycle later
    task automatic step(input logic [31:0] ins, input logic bub, input logic [25:0] cw_e,
                        input logic [2:0] br_e, input logic [31:0] imm_e);
        logic [31:0] t;
        logic [31:0] regb;
        logic [25:0] c;
        logic [2:0]  br;
        t       = rand32();
        c       = bub ? 26'd0 : cw_e;
        br      = bub ? 3'd0 : br_e;
        instr   = ins;
        bubble  = bub;
        pc_plus = t;
        pred    = t[17];
        regb      = model[c[CW_RS2 +: 5]];
        pend_ctrl = c;
        pend_br   = br;
        pend_a    = model[c[CW_RS1 +: 5]];
        pend_b    = c[CW_USE_IMM] ? imm_e : regb;
        pend_st   = regb;
        pend_pc   = t;
        pend_pred = t[17];
        @(negedge clk);
        check_outputs();
    endtask

    task automatic finish_test(input string name);
        $display("test %s: %s, %0d errors", name,
                 (errors == test_start_err) ? "ok" : "FAIL", errors - test_start_err);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_reset();
        test_start_err = errors;
        pend_ctrl = '0;
        pend_br   = '0;
        pend_a    = '0;
        pend_b    = '0;
        pend_st   = '0;
        pend_pc   = '0;
        pend_pred = 1'b0;
        // A live instruction during reset must not reach ID/EX
        instr   = enc_i(12'h5a3, 5'd3, 3'b000, 5'd5, OPC_OP_IMM);
        pc_plus = rand32() | 32'h4;
        pred    = 1'b1;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(negedge clk);
            check_outputs();
        end
        rst     = 1'b0;
        instr   = '0;
        pc_plus = '0;
        pred    = 1'b0;
        // Still a no-op before the first instruction
        @(negedge clk);
        check_outputs();
        finish_test("reset");
    endtask

    task automatic test_regfile();
        logic [4:0] rd;
        test_start_err = errors;
        for (int k = 1; k < 32; k++) begin
            set_wb(5'(k), rand32());
            step(32'h0, 1'b0, '0, BR_NONE, '0);
        end
        // x0 ignores writes even through the forwarding path
        set_wb(5'd0, rand32() | 32'h1);
        step(enc_r(7'b0, 5'd0, 5'd0, 3'b000, 5'd0, OPC_OP), 1'b0,
             cw(4'b0001, ALU_ADD, 3'b000, 5'd0, 5'd0, 5'd0), BR_NONE, '0);
        clear_wb();
        step(32'h0, 1'b0, '0, BR_NONE, '0);
        for (int k = 0; k < 32; k++) begin
            rd = rand_reg();
            step(enc_r(7'b0, 5'(31 - k), 5'(k), 3'b000, rd, OPC_OP), 1'b0,
                 cw(4'b0001, ALU_ADD, 3'b000, 5'(k), 5'(31 - k), rd), BR_NONE, '0);
        end
        finish_test("regfile");
    endtask

    task automatic test_forwarding();
        logic [31:0] t;
        logic [4:0]  k;
        test_start_err = errors;
        for (int n = 0; n < 8; n++) begin
            t = rand32();
            k = 5'(t % 31 + 1);
            set_wb(k, rand32());
            step(enc_r(7'b0, k, k, 3'b000, k, OPC_OP), 1'b0,
                 cw(4'b0001, ALU_ADD, 3'b000, k, k, k), BR_NONE, '0);
            clear_wb();
        end
        finish_test("forwarding");
    endtask

    task automatic test_immediates();
        logic [31:0] t;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        test_start_err = errors;
        for (int n = 0; n < N_RAND; n++) begin
            t   = rand32();
            rs1 = rand_reg();
            rs2 = rand_reg();
            rd  = rand_reg();
            step(enc_i(t[11:0], rs1, 3'b000, rd, OPC_OP_IMM), 1'b0,
                 cw(4'b1001, ALU_ADD, 3'b000, rs1, 5'd0, rd), BR_NONE, sext12(t[11:0]));
            step(enc_i(t[11:0], rs1, 3'b010, rd, OPC_LOAD), 1'b0,
                 cw(4'b1011, ALU_ADD, 3'b010, rs1, 5'd0, rd), BR_NONE, sext12(t[11:0]));
            step(enc_s(t[11:0], rs2, rs1, 3'b010), 1'b0,
                 cw(4'b1100, ALU_ADD, 3'b010, rs1, rs2, 5'd0), BR_NONE, sext12(t[11:0]));
            // Operand B stays register B for branches
            step(enc_b({t[12:1], 1'b0}, rs2, rs1, 3'b000), 1'b0,
                 cw(4'b0000, ALU_SUB, 3'b000, rs1, rs2, 5'd0), BR_EQ, '0);
            step({t[31:12], rd, OPC_LUI}, 1'b0,
                 cw(4'b1001, ALU_PASS_B, 3'b000, 5'd0, 5'd0, rd), BR_NONE,
                 {t[31:12], 12'b0});
            step({t[31:12], rd, OPC_AUIPC}, 1'b0,
                 cw(4'b1001, ALU_ADD, 3'b000, 5'd0, 5'd0, rd), BR_NONE, {t[31:12], 12'b0});
            step(enc_j({t[20:1], 1'b0}, rd), 1'b0,
                 cw(4'b1001, ALU_ADD, 3'b000, 5'd0, 5'd0, rd), BR_JUMP,
                 {{11{t[20]}}, t[20:1], 1'b0});
            step(enc_i(t[11:0], rs1, 3'b000, rd, OPC_JALR), 1'b0,
                 cw(4'b1001, ALU_ADD, 3'b000, rs1, 5'd0, rd), BR_JUMP, sext12(t[11:0]));
        end
        finish_test("immediates");
    endtask

    task automatic test_control();
        logic [31:0] t;
        logic [7:0]  ent;
        logic [6:0]  f7;
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        test_start_err = errors;
        for (int i = 0; i < 10; i++) begin
            t   = rand32();
            ent = R_TABLE[i];
            f7  = ent[7] ? 7'b0100000 : 7'b0000000;
            rs1 = t[4:0];
            rs2 = t[9:5];
            rd  = t[14:10];
            step(enc_r(f7, rs2, rs1, ent[6:4], rd, OPC_OP), 1'b0,
                 cw(4'b0001, ent[3:0], 3'b000, rs1, rs2, rd), BR_NONE, '0);
            // No SUBI
            if (!(ent[7] && ent[6:4] == 3'b000)) begin
                // Shift immediates carry funct7 and shamt
                imm = (ent[5:4] == 2'b01) ? {f7, rs2} : t[31:20];
                step(enc_i(imm, rs1, ent[6:4], rd, OPC_OP_IMM), 1'b0,
                     cw(4'b1001, ent[3:0], 3'b000, rs1, 5'd0, rd), BR_NONE, sext12(imm));
            end
        end
        for (int j = 0; j < 8; j++) begin
            t   = rand32();
            rs1 = t[4:0];
            rs2 = t[9:5];
            rd  = t[14:10];
            // LB LH LW LBU LHU
            if (j != 3 && j < 6) begin
                step(enc_i(t[31:20], rs1, 3'(j), rd, OPC_LOAD), 1'b0,
                     cw(4'b1011, ALU_ADD, 3'(j), rs1, 5'd0, rd), BR_NONE, sext12(t[31:20]));
            end
            if (j < 3) begin
                step(enc_s(t[31:20], rs2, rs1, 3'(j)), 1'b0,
                     cw(4'b1100, ALU_ADD, 3'(j), rs1, rs2, 5'd0), BR_NONE, sext12(t[31:20]));
            end
            if (j != 2 && j != 3) begin
                step(enc_b({t[31:20], 1'b0}, rs2, rs1, 3'(j)), 1'b0,
                     cw(4'b0000, ALU_SUB, 3'b000, rs1, rs2, 5'd0), BR_OF_F3[j], '0);
            end
        end
        // Unknown opcodes decode as no-ops
        for (int i = 0; i < 4; i++) begin
            t = rand32();
            step({t[31:7], BAD_OPC[i]}, 1'b0, '0, BR_NONE, '0);
        end
        finish_test("control");
    endtask

    task automatic test_bubbles();
        logic [31:0] t;
        logic [4:0]  rd;
        test_start_err = errors;
        // Consecutive cycles with a bubble on every other one
        for (int n = 0; n < N_RAND; n++) begin
            t  = rand32();
            rd = t[14:10];
            if (t[20]) begin
                step(enc_j({t[31:12], 1'b0}, rd), 1'(n % 2),
                     cw(4'b1001, ALU_ADD, 3'b000, 5'd0, 5'd0, rd), BR_JUMP,
                     {{11{t[31]}}, t[31:12], 1'b0});
            end else begin
                step(enc_r(7'b0, t[9:5], t[4:0], 3'b000, rd, OPC_OP), 1'(n % 2),
                     cw(4'b0001, ALU_ADD, 3'b000, t[4:0], t[9:5], rd), BR_NONE, '0);
            end
        end
        finish_test("bubbles");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        rst     = 1'b1;
        bubble  = 1'b0;
        instr   = '0;
        pc_plus = '0;
        pred    = 1'b0;
        wb_ctrl = '0;
        wb_data = '0;
        for (int i = 0; i < 32; i++) begin
            model[i] = '0;
        end
        test_reset();
        test_regfile();
        test_forwarding();
        test_immediates();
        test_control();
        test_bubbles();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== hw/id_top.sv ====
`timescale 1ns/1ns

module id_top
    import rv32i_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic                 bubble_i,
    input  logic [XLEN-1:0]      instr_i,
    input  logic [XLEN-1:0]      pc_plus_i,
    input  logic                 branch_prediction_i,
    input  logic [WB_CTRL_W-1:0] wb_ctrl_i,
    input  logic [XLEN-1:0]      wb_data_i,
    output logic [XLEN-1:0]      ex_data_a_o,
    output logic [XLEN-1:0]      ex_data_b_o,
    output logic [XLEN-1:0]      ex_store_data_o,
    output logic [XLEN-1:0]      ex_pc_plus_o,
    output logic [CTRL_W-1:0]    ex_ctrl_o,
    output branch_sel_e          ex_branch_sel_o,
    output logic                 ex_branch_prediction_o
);

    // Decode stage results ahead of the pipeline register
    logic [XLEN-1:0]   imm;
    logic              id_branch_prediction;
    logic [XLEN-1:0]   id_data_a;
    logic [XLEN-1:0]   id_data_b;
    logic [XLEN-1:0]   id_store_data;
    logic [XLEN-1:0]   id_pc_plus;
    logic [CTRL_W-1:0] id_ctrl;
    branch_sel_e       id_branch_sel;

    imm_gen u_imm_gen (
        .instr_i (instr_i),
        .imm_o   (imm)
    );

    decode_stage u_decode (
        .clk                 (clk),
        .rst_i               (rst_i),
        .bubble_i            (bubble_i),
        .instr_i             (instr_i),
        .imm_i               (imm),
        .pc_plus_i           (pc_plus_i),
        .branch_prediction_i (branch_prediction_i),
        .wb_ctrl_i           (wb_ctrl_i),
        .wb_data_i           (wb_data_i),
        .branch_prediction_o (id_branch_prediction),
        .data_a_o            (id_data_a),
        .data_b_o            (id_data_b),
        .store_data_o        (id_store_data),
        .pc_plus_o           (id_pc_plus),
        .ctrl_o              (id_ctrl),
        .branch_sel_o        (id_branch_sel)
    );

    ////////////////////////////////////////////////////////////////////////////
    // ID/EX boundary
    ////////////////////////////////////////////////////////////////////////////

    id_ex_reg u_id_ex (
        .clk                    (clk),
        .rst_i                  (rst_i),
        .branch_prediction_i    (id_branch_prediction),
        .data_a_i               (id_data_a),
        .data_b_i               (id_data_b),
        .store_data_i           (id_store_data),
        .pc_plus_i              (id_pc_plus),
        .ctrl_i                 (id_ctrl),
        .branch_sel_i           (id_branch_sel),
        .ex_branch_prediction_o (ex_branch_prediction_o),
        .ex_data_a_o            (ex_data_a_o),
        .ex_data_b_o            (ex_data_b_o),
        .ex_store_data_o        (ex_store_data_o),
        .ex_pc_plus_o           (ex_pc_plus_o),
        .ex_ctrl_o              (ex_ctrl_o),
        .ex_branch_sel_o        (ex_branch_sel_o)
    );

endmodule

// ==== hw/id_ex_reg.sv ====
`timescale 1ns/1ns

module id_ex_reg
    import rv32i_pkg::*;
(
    input  logic              clk,
    input  logic              rst_i,
    input  logic              branch_prediction_i,
    input  logic [XLEN-1:0]   data_a_i,
    input  logic [XLEN-1:0]   data_b_i,
    input  logic [XLEN-1:0]   store_data_i,
    input  logic [XLEN-1:0]   pc_plus_i,
    input  logic [CTRL_W-1:0] ctrl_i,
    input  branch_sel_e       branch_sel_i,
    output logic              ex_branch_prediction_o,
    output logic [XLEN-1:0]   ex_data_a_o,
    output logic [XLEN-1:0]   ex_data_b_o,
    output logic [XLEN-1:0]   ex_store_data_o,
    output logic [XLEN-1:0]   ex_pc_plus_o,
    output logic [CTRL_W-1:0] ex_ctrl_o,
    output branch_sel_e       ex_branch_sel_o
);

    // Loads every cycle, no stall input
    always_ff @(posedge clk) begin
        if (rst_i) begin
            ex_branch_prediction_o <= 1'b0;
            ex_data_a_o            <= '0;
            ex_data_b_o            <= '0;
            ex_store_data_o        <= '0;
            ex_pc_plus_o           <= '0;
            ex_ctrl_o              <= '0;
            ex_branch_sel_o        <= BR_NONE;
        end else begin
            ex_branch_prediction_o <= branch_prediction_i;
            ex_data_a_o            <= data_a_i;
            ex_data_b_o            <= data_b_i;
            ex_store_data_o        <= store_data_i;
            ex_pc_plus_o           <= pc_plus_i;
            ex_ctrl_o              <= ctrl_i;
            ex_branch_sel_o        <= branch_sel_i;
        end
    end

    // Execute sees a no-op right after reset
    assert property (@(posedge clk)
        rst_i |=> (ex_ctrl_o == '0 && ex_branch_sel_o == BR_NONE))
        else $error("ID/EX not cleared after reset");

endmodule

// ==== hw/decode_stage.sv ====
`timescale 1ns/1ns

module decode_stage
    import rv32i_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic                 bubble_i,
    input  logic [XLEN-1:0]      instr_i,
    input  logic [XLEN-1:0]      imm_i,
    input  logic [XLEN-1:0]      pc_plus_i,
    input  logic                 branch_prediction_i,
    // Writeback register write
    input  logic [WB_CTRL_W-1:0] wb_ctrl_i,
    input  logic [XLEN-1:0]      wb_data_i,
    output logic                 branch_prediction_o,
    output logic [XLEN-1:0]      data_a_o,
    output logic [XLEN-1:0]      data_b_o,
    output logic [XLEN-1:0]      store_data_o,
    output logic [XLEN-1:0]      pc_plus_o,
    output logic [CTRL_W-1:0]    ctrl_o,
    output branch_sel_e          branch_sel_o
);

    logic [XLEN-1:0] reg_b;

    rv32i_decoder u_decoder (
        .instr_i      (instr_i),
        .bubble_i     (bubble_i),
        .ctrl_o       (ctrl_o),
        .branch_sel_o (branch_sel_o)
    );

    // Read ports addressed by the decoded source fields
    register_file u_regfile (
        .clk       (clk),
        .rst_i     (rst_i),
        .we_i      (wb_ctrl_i[0]),
        .wr_addr_i (wb_ctrl_i[WB_CTRL_W-1:1]),
        .wr_data_i (wb_data_i),
        .a_sel_i   (ctrl_o[CW_RS1 +: REG_ADDR_W]),
        .b_sel_i   (ctrl_o[CW_RS2 +: REG_ADDR_W]),
        .a_o       (data_a_o),
        .b_o       (reg_b)
    );

    // Operand B mux
    assign data_b_o     = ctrl_o[CW_USE_IMM] ? imm_i : reg_b;
    // Store data always from rs2
    assign store_data_o = reg_b;

    assign pc_plus_o           = pc_plus_i;
    assign branch_prediction_o = branch_prediction_i;

    // Bubble reaches the stage outputs as a no-op
    assert property (@(posedge clk) disable iff (rst_i)
        bubble_i |-> (ctrl_o == '0 && branch_sel_o == BR_NONE))
        else $error("bubble did not produce a no-op");

endmodule

// ==== hw/register_file.sv ====
`timescale 1ns/1ns

module register_file
    import rv32i_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic                  we_i,
    input  logic [REG_ADDR_W-1:0] wr_addr_i,
    input  logic [XLEN-1:0]       wr_data_i,
    input  logic [REG_ADDR_W-1:0] a_sel_i,
    input  logic [REG_ADDR_W-1:0] b_sel_i,
    output logic [XLEN-1:0]       a_o,
    output logic [XLEN-1:0]       b_o
);

    logic [XLEN-1:0] regs [NUM_REGS];
    logic            wr_valid;
    logic            fwd_a;
    logic            fwd_b;

    // x0 is never written
    assign wr_valid = we_i && (wr_addr_i != '0);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_valid) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reads with write-through from writeback
    ////////////////////////////////////////////////////////////////////////////

    assign fwd_a = wr_valid && (wr_addr_i == a_sel_i);
    assign fwd_b = wr_valid && (wr_addr_i == b_sel_i);

    // Same-cycle write wins over the stored value
    assign a_o = fwd_a ? wr_data_i : regs[a_sel_i];
    assign b_o = fwd_b ? wr_data_i : regs[b_sel_i];

    // Writes aimed at x0 leave both read ports at zero now and afterwards
    assert property (@(posedge clk) disable iff (rst_i)
        (we_i && wr_addr_i == '0) |->
            ((a_sel_i != '0 || a_o == '0) && (b_sel_i != '0 || b_o == '0))
            ##1 (regs[0] == '0))
        else $error("x0 read non-zero after write to x0");

endmodule

// ==== hw/rv32i_decoder.sv ====
`timescale 1ns/1ns

module rv32i_decoder
    import rv32i_pkg::*;
(
    input  logic [XLEN-1:0]   instr_i,
    input  logic              bubble_i,
    output logic [CTRL_W-1:0] ctrl_o,
    output branch_sel_e       branch_sel_o
);

    // Map funct3 onto an ALU operation, alt picks SUB or SRA
    function automatic alu_op_e alu_from_funct3(input logic [FUNCT3_W-1:0] f3,
                                                input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    opcode_e               opcode;
    logic [FUNCT3_W-1:0]   funct3;
    logic                  f7_zero;
    logic                  f7_alt;
    logic                  legal;
    logic                  reg_write;
    logic                  mem_read;
    logic                  mem_write;
    logic                  use_imm;
    logic                  use_rs1;
    logic                  use_rs2;
    logic                  pass_f3;
    alu_op_e               alu_op;
    branch_sel_e           br_sel;

    assign opcode  = opcode_e'(instr_i[6:0]);
    assign funct3  = instr_i[14:12];
    assign f7_zero = (instr_i[31:25] == 7'b0000000);
    assign f7_alt  = (instr_i[31:25] == 7'b0100000);

    ////////////////////////////////////////////////////////////////////////////
    // Per-opcode decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        legal     = 1'b1;
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        use_imm   = 1'b0;
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        pass_f3   = 1'b0;
        alu_op    = ALU_ADD;
        br_sel    = BR_NONE;
        case (opcode)
            OPC_OP: begin
                // Only ADD/SUB and SRL/SRA have an alternate encoding
                legal     = f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101));
                reg_write = 1'b1;
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
                alu_op    = alu_from_funct3(funct3, f7_alt);
            end
            OPC_OP_IMM: begin
                // Shift immediates carry funct7 in the upper bits
                if (funct3 == 3'b001) begin
                    legal = f7_zero;
                end else if (funct3 == 3'b101) begin
                    legal = f7_zero || f7_alt;
                end
                reg_write = 1'b1;
                use_imm   = 1'b1;
                use_rs1   = 1'b1;
                alu_op    = alu_from_funct3(funct3, funct3 == 3'b101 && f7_alt);
            end
            OPC_LOAD: begin
                // LB LH LW LBU LHU
                legal     = funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
                reg_write = 1'b1;
                mem_read  = 1'b1;
                use_imm   = 1'b1;
                use_rs1   = 1'b1;
                pass_f3   = 1'b1;
            end
            OPC_STORE: begin
                legal     = funct3 inside {3'b000, 3'b001, 3'b010};
                mem_write = 1'b1;
                use_imm   = 1'b1;
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
                pass_f3   = 1'b1;
            end
            OPC_BRANCH: begin
                // Compare in the ALU, kind goes out on the branch selector
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                alu_op  = ALU_SUB;
                case (funct3)
                    3'b000:  br_sel = BR_EQ;
                    3'b001:  br_sel = BR_NE;
                    3'b100:  br_sel = BR_LT;
                    3'b101:  br_sel = BR_GE;
                    3'b110:  br_sel = BR_LTU;
                    3'b111:  br_sel = BR_GEU;
                    default: legal  = 1'b0;
                endcase
            end
            OPC_LUI: begin
                reg_write = 1'b1;
                use_imm   = 1'b1;
                alu_op    = ALU_PASS_B;
            end
            OPC_AUIPC: begin
                // Execute adds the pc to the immediate
                reg_write = 1'b1;
                use_imm   = 1'b1;
            end
            OPC_JAL: begin
                // Link value is pc-plus, selected downstream
                reg_write = 1'b1;
                use_imm   = 1'b1;
                br_sel    = BR_JUMP;
            end
            OPC_JALR: begin
                legal     = (funct3 == 3'b000);
                reg_write = 1'b1;
                use_imm   = 1'b1;
                use_rs1   = 1'b1;
                br_sel    = BR_JUMP;
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Control word assembly
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        ctrl_o       = '0;
        branch_sel_o = BR_NONE;
        // Bubbles and illegal encodings leave a no-op
        if (legal && !bubble_i) begin
            ctrl_o[CW_REG_WRITE]                = reg_write;
            ctrl_o[CW_MEM_READ]                 = mem_read;
            ctrl_o[CW_MEM_WRITE]                = mem_write;
            ctrl_o[CW_USE_IMM]                  = use_imm;
            ctrl_o[CW_ALU_OP +: ALU_OP_W]       = alu_op;
            ctrl_o[CW_FUNCT3 +: FUNCT3_W]       = pass_f3 ? funct3 : '0;
            // Register fields only for formats that carry them
            ctrl_o[CW_RS1 +: REG_ADDR_W]        = use_rs1 ? instr_i[19:15] : '0;
            ctrl_o[CW_RS2 +: REG_ADDR_W]        = use_rs2 ? instr_i[24:20] : '0;
            ctrl_o[CW_RD +: REG_ADDR_W]         = reg_write ? instr_i[11:7] : '0;
            branch_sel_o                        = br_sel;
        end
    end

endmodule

// ==== hw/imm_gen.sv ====
`timescale 1ns/1ns

module imm_gen
    import rv32i_pkg::*;
(
    input  logic [XLEN-1:0] instr_i,
    output logic [XLEN-1:0] imm_o
);

    opcode_e opcode;
    logic    sign;

    assign opcode = opcode_e'(instr_i[6:0]);
    // Bit 31 is the sign bit in every format
    assign sign   = instr_i[31];

    always_comb begin
        case (opcode)
            // I format
            OPC_OP_IMM, OPC_LOAD, OPC_JALR: begin
                imm_o = {{20{sign}}, instr_i[31:20]};
            end
            // S format, split offset
            OPC_STORE: begin
                imm_o = {{20{sign}}, instr_i[31:25], instr_i[11:7]};
            end
            // B format, offset in halfwords
            OPC_BRANCH: begin
                imm_o = {{19{sign}}, instr_i[31], instr_i[7], instr_i[30:25],
                         instr_i[11:8], 1'b0};
            end
            // U format, upper 20 bits
            OPC_LUI, OPC_AUIPC: begin
                imm_o = {instr_i[31:12], 12'b0};
            end
            // J format
            OPC_JAL: begin
                imm_o = {{11{sign}}, instr_i[31], instr_i[19:12], instr_i[20],
                         instr_i[30:21], 1'b0};
            end
            // R format and unknown opcodes
            default: begin
                imm_o = '0;
            end
        endcase
    end

endmodule

// ==== hw/rv32i_pkg.sv ====
package rv32i_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 1 << REG_ADDR_W;
    localparam int CTRL_W     = 26;
    // Bit 0 is write enable, bits 5..1 the destination register
    localparam int WB_CTRL_W  = 6;
    localparam int ALU_OP_W   = 4;
    localparam int BR_SEL_W   = 3;
    localparam int FUNCT3_W   = 3;

    ////////////////////////////////////////////////////////////////////////////
    // Control word layout, an all-zero word is a no-op
    ////////////////////////////////////////////////////////////////////////////

    localparam int CW_REG_WRITE = 0;
    localparam int CW_MEM_READ  = 1;
    localparam int CW_MEM_WRITE = 2;
    localparam int CW_USE_IMM   = 3;
    // Multi-bit fields are given by their lowest bit
    localparam int CW_ALU_OP    = 4;
    localparam int CW_FUNCT3    = 8;
    localparam int CW_RS1       = 11;
    localparam int CW_RS2       = 16;
    localparam int CW_RD        = 21;

    // RV32I major opcodes handled by the decoder
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } opcode_e;

    // Execute stage ALU operations
    typedef enum logic [ALU_OP_W-1:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    // Branch kind resolved in execute
    typedef enum logic [BR_SEL_W-1:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JUMP
    } branch_sel_e;

endpackage
